/* source/cache_pkg.sv */
// ########################################
// Definitions shared by the cache bank
// Import in the module body where the
// enums or the word width are needed
// ########################################

package cache_pkg;

    // Data width of one APB word
    localparam int WORD_WIDTH = 32;

    // Controller states
    typedef enum logic [2:0] {
        ST_INIT,
        ST_IDLE,
        ST_LOOKUP,
        ST_WBACK,
        ST_FILL,
        ST_FILL_WAIT,
        ST_DONE
    } ctrl_state_e;

    // Operations on the line storage
    typedef enum logic [2:0] {
        DOP_IDLE,
        DOP_READ,
        DOP_WRITE,
        DOP_FILL,
        DOP_FLUSH
    } data_op_e;

endpackage

/* source/cache_ctrl.sv */
// ########################################
// Control FSM of the cache bank
// Serves one APB transfer at a time: hit
// service, or writeback then line fill
// ########################################

module cache_ctrl #(
    parameter int NUM_LINES  = 8,
    parameter int LINE_WORDS = 4,
    parameter int MEM_WORDS  = 256,
    localparam int ADDR_W = $clog2(MEM_WORDS),
    localparam int IDX_W  = $clog2(NUM_LINES),
    localparam int WSEL_W = $clog2(LINE_WORDS),
    localparam int TAG_W  = ADDR_W - IDX_W - WSEL_W,
    localparam int CNT_W  = $clog2(NUM_LINES > LINE_WORDS ? NUM_LINES : LINE_WORDS)
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [31:0]                         paddr,
    input  logic [cache_pkg::WORD_WIDTH-1:0]    pwdata,
    input  logic [cache_pkg::WORD_WIDTH/8-1:0]  pstrb,
    output logic [cache_pkg::WORD_WIDTH-1:0]    prdata,
    output logic                                pready,
    output logic                                pslverr,
    input  logic                                hit,
    input  logic                                victim_dirty,
    input  logic [TAG_W-1:0]                    victim_tag,
    output logic [IDX_W-1:0]                    index,
    output logic [TAG_W-1:0]                    tag_in,
    output logic                                tag_set_valid,
    output logic                                tag_set_dirty,
    output logic                                tag_clear,
    input  logic [CNT_W-1:0]                    beat,
    input  logic                                beat_last,
    output logic                                beat_start,
    output logic                                beat_step,
    output logic [CNT_W-1:0]                    beat_limit,
    output cache_pkg::data_op_e                 op,
    output logic [WSEL_W-1:0]                   wsel,
    output logic [cache_pkg::WORD_WIDTH-1:0]    wdata,
    output logic [cache_pkg::WORD_WIDTH/8-1:0]  byteen,
    output logic [cache_pkg::WORD_WIDTH-1:0]    fill_word,
    input  logic [cache_pkg::WORD_WIDTH-1:0]    rdata,
    output logic [ADDR_W-1:0]                   mem_addr,
    output logic                                mem_read,
    output logic                                mem_write,
    output logic [cache_pkg::WORD_WIDTH-1:0]    mem_wdata,
    input  logic [cache_pkg::WORD_WIDTH-1:0]    mem_rdata
);
    import cache_pkg::*;

    ctrl_state_e        state;
    ctrl_state_e        next_state;
    logic [ADDR_W-1:0]  word_addr;
    logic [WSEL_W-1:0]  req_wsel;
    logic [IDX_W-1:0]   req_index;
    logic [TAG_W-1:0]   req_tag;
    logic               misaligned;
    logic               wb_pend;
    logic               fill_pend;
    logic [WSEL_W-1:0]  pend_word;

    // Byte address split into tag, line index and word select
    assign word_addr  = paddr[2 +: ADDR_W];
    assign req_wsel   = word_addr[WSEL_W-1:0];
    assign req_index  = word_addr[WSEL_W +: IDX_W];
    assign req_tag    = word_addr[ADDR_W-1 -: TAG_W];
    assign misaligned = (paddr[1:0] != 2'b00);

    always_comb begin
        next_state    = state;
        index         = req_index;
        tag_set_valid = 1'b0;
        tag_set_dirty = 1'b0;
        tag_clear     = 1'b0;
        beat_step     = 1'b0;
        beat_limit    = CNT_W'(LINE_WORDS - 1);
        op            = DOP_IDLE;
        wsel          = req_wsel;
        mem_read      = 1'b0;
        case (state)
            ST_INIT: begin
                index      = beat[IDX_W-1:0];
                tag_clear  = 1'b1;
                beat_step  = 1'b1;
                beat_limit = CNT_W'(NUM_LINES - 1);
                if (beat_last) begin
                    next_state = ST_IDLE;
                end
            end
            ST_IDLE: begin
                if (psel) begin
                    next_state = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                if (misaligned) begin
                    next_state = ST_DONE;
                end else if (hit) begin
                    op            = pwrite ? DOP_WRITE : DOP_READ;
                    tag_set_dirty = pwrite;
                    next_state    = ST_DONE;
                end else begin
                    next_state = victim_dirty ? ST_WBACK : ST_FILL;
                end
            end
            ST_WBACK: begin
                // Victim word goes to memory one cycle after its RAM read
                op        = DOP_FLUSH;
                wsel      = beat[WSEL_W-1:0];
                beat_step = 1'b1;
                if (beat_last) begin
                    next_state = ST_FILL_WAIT;
                end
            end
            ST_FILL: begin
                mem_read  = 1'b1;
                beat_step = 1'b1;
                if (beat_last) begin
                    next_state = ST_FILL_WAIT;
                end
            end
            ST_FILL_WAIT: begin
                // Drains the last writeback or fill word
                if (wb_pend) begin
                    next_state = ST_FILL;
                end else begin
                    tag_set_valid = 1'b1;
                    next_state    = ST_LOOKUP;
                end
            end
            ST_DONE: next_state = ST_IDLE;
            default: next_state = ST_INIT;
        endcase
        // Fill data returns a cycle after each memory read
        if (fill_pend) begin
            op   = DOP_FILL;
            wsel = pend_word;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_INIT;
            wb_pend   <= 1'b0;
            fill_pend <= 1'b0;
        end else begin
            state     <= next_state;
            wb_pend   <= (state == ST_WBACK);
            fill_pend <= (state == ST_FILL);
        end
    end

    always_ff @(posedge clk) begin
        pend_word <= beat[WSEL_W-1:0];
    end

    // Counter returns to zero at the end of every sweep
    assign beat_start = beat_step && beat_last;

    assign tag_in    = req_tag;
    assign wdata     = pwdata;
    assign byteen    = pstrb;
    assign fill_word = mem_rdata;

    assign mem_write = wb_pend;
    assign mem_wdata = rdata;
    assign mem_addr  = wb_pend ? {victim_tag, req_index, pend_word}
                               : {req_tag, req_index, beat[WSEL_W-1:0]};

    assign pready  = (state == ST_DONE);
    assign pslverr = pready && misaligned;
    assign prdata  = (misaligned || pwrite) ? '0 : rdata;

    a_pready_in_access: assert property (@(posedge clk) disable iff (!rst_n)
        pready |-> psel && penable);

    a_mem_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_read && mem_write));

endmodule

/* source/cache_beat_counter.sv */
// ########################################
// Beat counter for init and line transfers
// The controller supplies the terminal
// count for each sweep
// ########################################

module cache_beat_counter #(
    parameter int COUNT_MAX = 8,
    localparam int CNT_W = $clog2(COUNT_MAX)
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             beat_start,
    input  logic             beat_step,
    input  logic [CNT_W-1:0] beat_limit,
    output logic [CNT_W-1:0] beat,
    output logic             beat_last
);

    // Start wins over step so a sweep ends at zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat <= '0;
        end else if (beat_start) begin
            beat <= '0;
        end else if (beat_step) begin
            beat <= beat + 1'b1;
        end
    end

    assign beat_last = (beat == beat_limit);

    a_within_limit: assert property (@(posedge clk) disable iff (!rst_n)
        beat <= beat_limit);

endmodule

/* source/cache_tag_store.sv */
// ########################################
// Per-line tag, valid and dirty state
// Lookup is combinational on the index,
// updates land on the clock edge
// ########################################

module cache_tag_store #(
    parameter int NUM_LINES  = 8,
    parameter int LINE_WORDS = 4,
    parameter int MEM_WORDS  = 256,
    localparam int IDX_W = $clog2(NUM_LINES),
    localparam int TAG_W = $clog2(MEM_WORDS) - IDX_W - $clog2(LINE_WORDS)
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [IDX_W-1:0] index,
    input  logic [TAG_W-1:0] tag_in,
    input  logic             tag_set_valid,
    input  logic             tag_set_dirty,
    input  logic             tag_clear,
    output logic             hit,
    output logic             victim_dirty,
    output logic [TAG_W-1:0] victim_tag
);

    logic [TAG_W-1:0]     tags [NUM_LINES];
    logic [NUM_LINES-1:0] valid;
    logic [NUM_LINES-1:0] dirty;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= '0;
            dirty <= '0;
        end else if (tag_clear) begin
            valid[index] <= 1'b0;
            dirty[index] <= 1'b0;
        end else if (tag_set_valid) begin
            // Freshly filled line matches memory
            valid[index] <= 1'b1;
            dirty[index] <= 1'b0;
        end else if (tag_set_dirty) begin
            dirty[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tag_set_valid) begin
            tags[index] <= tag_in;
        end
    end

    assign hit          = valid[index] && (tags[index] == tag_in);
    assign victim_dirty = valid[index] && dirty[index];
    assign victim_tag   = tags[index];

endmodule

/* source/cache_data_store.sv */
// ########################################
// Line storage of the cache bank
// Single-port RAM of NUM_LINES lines with
// byte-enabled writes and one-cycle reads
// ########################################

module cache_data_store #(
    parameter int NUM_LINES  = 8,
    parameter int LINE_WORDS = 4,
    localparam int IDX_W  = $clog2(NUM_LINES),
    localparam int WSEL_W = $clog2(LINE_WORDS)
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  cache_pkg::data_op_e                 op,
    input  logic [IDX_W-1:0]                    index,
    input  logic [WSEL_W-1:0]                   wsel,
    input  logic [cache_pkg::WORD_WIDTH-1:0]    wdata,
    input  logic [cache_pkg::WORD_WIDTH/8-1:0]  byteen,
    input  logic [cache_pkg::WORD_WIDTH-1:0]    fill_word,
    output logic [cache_pkg::WORD_WIDTH-1:0]    rdata
);
    import cache_pkg::*;

    localparam int BYTES = WORD_WIDTH / 8;

    logic [WORD_WIDTH-1:0]   ram [NUM_LINES * LINE_WORDS];
    logic [IDX_W+WSEL_W-1:0] addr;

    // Words of a line sit next to each other
    assign addr = {index, wsel};

    always_ff @(posedge clk) begin
        case (op)
            DOP_WRITE: begin
                for (int b = 0; b < BYTES; b++) begin
                    if (byteen[b]) begin
                        ram[addr][8*b +: 8] <= wdata[8*b +: 8];
                    end
                end
            end
            DOP_FILL: begin
                ram[addr] <= fill_word;
            end
            // Flush reads the victim word for writeback
            DOP_READ, DOP_FLUSH: begin
                rdata <= ram[addr];
            end
            default: begin
            end
        endcase
    end

    a_op_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(op));

endmodule

/* source/backing_mem.sv */
// ########################################
// Word-addressed main memory behind the
// cache, one-cycle read, starts all zero
// ########################################

module backing_mem #(
    parameter int MEM_WORDS = 256,
    localparam int ADDR_W = $clog2(MEM_WORDS)
) (
    input  logic                             clk,
    input  logic [ADDR_W-1:0]                mem_addr,
    input  logic                             mem_read,
    input  logic                             mem_write,
    input  logic [cache_pkg::WORD_WIDTH-1:0] mem_wdata,
    output logic [cache_pkg::WORD_WIDTH-1:0] mem_rdata
);

    logic [cache_pkg::WORD_WIDTH-1:0] mem [MEM_WORDS];

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_write) begin
            mem[mem_addr] <= mem_wdata;
        end
        if (mem_read) begin
            mem_rdata <= mem[mem_addr];
        end
    end

endmodule

/* source/cache_apb_top.sv */
// ########################################
// Write-back cache bank with APB slave
// Wires the controller to the counter,
// tag and data stores and main memory
// ########################################

module cache_apb_top #(
    parameter int NUM_LINES  = 8,
    parameter int LINE_WORDS = 4,
    parameter int MEM_WORDS  = 256
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [31:0]                         paddr,
    input  logic [cache_pkg::WORD_WIDTH-1:0]    pwdata,
    input  logic [cache_pkg::WORD_WIDTH/8-1:0]  pstrb,
    output logic [cache_pkg::WORD_WIDTH-1:0]    prdata,
    output logic                                pready,
    output logic                                pslverr
);
    import cache_pkg::*;

    localparam int ADDR_W    = $clog2(MEM_WORDS);
    localparam int IDX_W     = $clog2(NUM_LINES);
    localparam int WSEL_W    = $clog2(LINE_WORDS);
    localparam int TAG_W     = ADDR_W - IDX_W - WSEL_W;
    localparam int COUNT_MAX = NUM_LINES > LINE_WORDS ? NUM_LINES : LINE_WORDS;
    localparam int CNT_W     = $clog2(COUNT_MAX);

    logic                     hit;
    logic                     victim_dirty;
    logic [TAG_W-1:0]         victim_tag;
    logic [IDX_W-1:0]         index;
    logic [TAG_W-1:0]         tag_in;
    logic                     tag_set_valid;
    logic                     tag_set_dirty;
    logic                     tag_clear;
    logic [CNT_W-1:0]         beat;
    logic                     beat_last;
    logic                     beat_start;
    logic                     beat_step;
    logic [CNT_W-1:0]         beat_limit;
    data_op_e                 op;
    logic [WSEL_W-1:0]        wsel;
    logic [WORD_WIDTH-1:0]    wdata;
    logic [WORD_WIDTH/8-1:0]  byteen;
    logic [WORD_WIDTH-1:0]    fill_word;
    logic [WORD_WIDTH-1:0]    rdata;
    logic [ADDR_W-1:0]        mem_addr;
    logic                     mem_read;
    logic                     mem_write;
    logic [WORD_WIDTH-1:0]    mem_wdata;
    logic [WORD_WIDTH-1:0]    mem_rdata;

    cache_ctrl #(
        .NUM_LINES  (NUM_LINES),
        .LINE_WORDS (LINE_WORDS),
        .MEM_WORDS  (MEM_WORDS)
    ) u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .paddr         (paddr),
        .pwdata        (pwdata),
        .pstrb         (pstrb),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr),
        .hit           (hit),
        .victim_dirty  (victim_dirty),
        .victim_tag    (victim_tag),
        .index         (index),
        .tag_in        (tag_in),
        .tag_set_valid (tag_set_valid),
        .tag_set_dirty (tag_set_dirty),
        .tag_clear     (tag_clear),
        .beat          (beat),
        .beat_last     (beat_last),
        .beat_start    (beat_start),
        .beat_step     (beat_step),
        .beat_limit    (beat_limit),
        .op            (op),
        .wsel          (wsel),
        .wdata         (wdata),
        .byteen        (byteen),
        .fill_word     (fill_word),
        .rdata         (rdata),
        .mem_addr      (mem_addr),
        .mem_read      (mem_read),
        .mem_write     (mem_write),
        .mem_wdata     (mem_wdata),
        .mem_rdata     (mem_rdata)
    );

    cache_beat_counter #(
        .COUNT_MAX (COUNT_MAX)
    ) u_beat (
        .clk        (clk),
        .rst_n      (rst_n),
        .beat_start (beat_start),
        .beat_step  (beat_step),
        .beat_limit (beat_limit),
        .beat       (beat),
        .beat_last  (beat_last)
    );

    cache_tag_store #(
        .NUM_LINES  (NUM_LINES),
        .LINE_WORDS (LINE_WORDS),
        .MEM_WORDS  (MEM_WORDS)
    ) u_tags (
        .clk           (clk),
        .rst_n         (rst_n),
        .index         (index),
        .tag_in        (tag_in),
        .tag_set_valid (tag_set_valid),
        .tag_set_dirty (tag_set_dirty),
        .tag_clear     (tag_clear),
        .hit           (hit),
        .victim_dirty  (victim_dirty),
        .victim_tag    (victim_tag)
    );

    cache_data_store #(
        .NUM_LINES  (NUM_LINES),
        .LINE_WORDS (LINE_WORDS)
    ) u_data (
        .clk       (clk),
        .rst_n     (rst_n),
        .op        (op),
        .index     (index),
        .wsel      (wsel),
        .wdata     (wdata),
        .byteen    (byteen),
        .fill_word (fill_word),
        .rdata     (rdata)
    );

    backing_mem #(
        .MEM_WORDS (MEM_WORDS)
    ) u_mem (
        .clk       (clk),
        .mem_addr  (mem_addr),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

endmodule

/* verification/cache_tb.sv */
// ########################################
// Testbench for the APB cache bank
// Random APB traffic from a fixed seed is
// checked against a flat memory model and
// a shadow of the direct-mapped tags
// ########################################

module cache_tb;

    localparam int NUM_LINES       = 8;
    localparam int LINE_WORDS      = 4;
    localparam int MEM_WORDS       = 256;
    localparam int ADDR_W          = $clog2(MEM_WORDS);
    localparam int IDX_W           = $clog2(NUM_LINES);
    localparam int WSEL_W          = $clog2(LINE_WORDS);
    localparam int TAG_W           = ADDR_W - IDX_W - WSEL_W;
    localparam int CLK_PERIOD      = 10;
    localparam int NUM_RANDOM      = 200;
    localparam int TOTAL_TRANSFERS = 4 + NUM_RANDOM + 6 + 4 * NUM_LINES;
    // Setup, dirty writeback, fill, final lookup and idle gap
    localparam int WORST_CYCLES    = 2 * LINE_WORDS + 9;
    localparam int TIMEOUT_CYCLES  = TOTAL_TRANSFERS * WORST_CYCLES + NUM_LINES + 100;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] paddr;
    logic [31:0] pwdata;
    logic [3:0]  pstrb;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    integer      seed = 94164;

    // Reference model of main memory and of the cache placement
    logic [31:0]      model_mem [MEM_WORDS];
    logic [TAG_W-1:0] shadow_tag [NUM_LINES];
    logic             shadow_valid [NUM_LINES];

    cache_apb_top #(
        .NUM_LINES  (NUM_LINES),
        .LINE_WORDS (LINE_WORDS),
        .MEM_WORDS  (MEM_WORDS)
    ) DUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .pstrb   (pstrb),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #5 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Error: %s expected %h got %h", name, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1, "Value mismatch");
        end
    endtask

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] data,
                                                input logic [3:0]  strb);
        logic [31:0] result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                result[8*b +: 8] = data[8*b +: 8];
            end
        end
        return result;
    endfunction

    // One APB transfer that counts the cycles of its access phase
    task automatic apb_transfer(input logic wr, input logic [31:0] addr,
                                input logic [31:0] data, input logic [3:0] strb,
                                output logic [31:0] rd, output logic err,
                                output int cycles);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        pstrb   = strb;
        @(posedge clk);
        #1;
        penable = 1'b1;
        cycles  = 1;
        while (!pready) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        rd  = prdata;
        err = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // Runs one transfer and checks data, error and latency against the model
    task automatic do_access(input logic wr, input logic [31:0] addr,
                             input logic [31:0] data, input logic [3:0] strb);
        logic [ADDR_W-1:0] waddr;
        logic [IDX_W-1:0]  idx;
        logic [TAG_W-1:0]  tag;
        logic              aligned;
        logic              predicted_hit;
        logic [31:0]       expected;
        logic [31:0]       rd;
        logic              err;
        int                cycles;
        waddr         = addr[2 +: ADDR_W];
        idx           = waddr[WSEL_W +: IDX_W];
        tag           = waddr[ADDR_W-1 -: TAG_W];
        aligned       = (addr[1:0] == 2'b00);
        predicted_hit = shadow_valid[idx] && (shadow_tag[idx] == tag);
        expected      = (aligned && !wr) ? model_mem[waddr] : 32'h0;
        apb_transfer(wr, addr, data, strb, rd, err, cycles);
        check_value("pslverr", {31'b0, !aligned}, {31'b0, err});
        check_value("prdata", expected, rd);
        if (!aligned || predicted_hit) begin
            check_value("access_cycles", 32'd2, cycles);
        end else begin
            check_value("miss_latency_over_2", 32'd1, {31'b0, cycles > 2});
        end
        if (aligned) begin
            if (wr) begin
                model_mem[waddr] = merge_bytes(model_mem[waddr], data, strb);
            end
            shadow_valid[idx] = 1'b1;
            shadow_tag[idx]   = tag;
        end
    endtask

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Run timed out: the DUT did not finish its transfers in time");
        $display("SOME TESTS FAILED");
        $fatal(1, "Timeout");
    end

    initial begin
        logic [31:0]       rnd;
        logic [31:0]       rnd2;
        logic [31:0]       addr;
        logic [31:0]       data;
        logic [ADDR_W-1:0] waddr;
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = 32'h0;
        pwdata  = 32'h0;
        pstrb   = 4'h0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            model_mem[i] = 32'h0;
        end
        for (int i = 0; i < NUM_LINES; i++) begin
            shadow_valid[i] = 1'b0;
            shadow_tag[i]   = '0;
        end
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_value("pready", 32'h0, {31'b0, pready});
        check_value("pslverr", 32'h0, {31'b0, pslverr});

        // Clean memory after reset and init
        for (int i = 0; i < 4; i++) begin
            rnd = $random(seed);
            do_access(1'b0, 32'(ADDR_W'(rnd)) << 2, 32'h0, 4'hf);
        end

        // Conflicting traffic over three tags with some misaligned accesses
        for (int i = 0; i < NUM_RANDOM; i++) begin
            rnd   = $random(seed);
            rnd2  = $random(seed);
            waddr = ADDR_W'(rnd % 32'd96);
            addr  = {rnd2[31:ADDR_W+2], waddr, 2'b00};
            if (rnd2[11:8] == 4'h0) begin
                addr[1:0] = (rnd2[13:12] == 2'b00) ? 2'b10 : rnd2[13:12];
            end
            data = $random(seed);
            do_access(rnd2[0], addr, data, rnd2[7:4]);
        end

        // Write without strobes keeps the word
        do_access(1'b0, 32'h0000_0040, 32'h0, 4'hf);
        do_access(1'b1, 32'h0000_0040, 32'hdead_beef, 4'h0);
        do_access(1'b0, 32'h0000_0040, 32'h0, 4'hf);

        // Misaligned write stores nothing, with its line held in the cache
        do_access(1'b0, 32'h0000_0080, 32'h0, 4'hf);
        do_access(1'b1, 32'h0000_0083, 32'h1234_5678, 4'hf);
        do_access(1'b0, 32'h0000_0080, 32'h0, 4'hf);

        // Every line dirty with its own tag, then evicted and read back
        for (int i = 0; i < NUM_LINES; i++) begin
            waddr = {TAG_W'(i), IDX_W'(i), WSEL_W'(i)};
            data  = $random(seed);
            do_access(1'b1, 32'(waddr) << 2, data, 4'hf);
        end
        for (int i = 0; i < NUM_LINES; i++) begin
            waddr = {TAG_W'(i + 4), IDX_W'(i), WSEL_W'(i)};
            data  = $random(seed);
            do_access(1'b1, 32'(waddr) << 2, data, 4'hf);
        end
        for (int i = 0; i < NUM_LINES; i++) begin
            waddr = {TAG_W'(i), IDX_W'(i), WSEL_W'(i)};
            do_access(1'b0, 32'(waddr) << 2, 32'h0, 4'hf);
        end
        for (int i = 0; i < NUM_LINES; i++) begin
            waddr = {TAG_W'(i + 4), IDX_W'(i), WSEL_W'(i)};
            do_access(1'b0, 32'(waddr) << 2, 32'h0, 4'hf);
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* files.f */
source/cache_pkg.sv
source/cache_ctrl.sv
source/cache_beat_counter.sv
source/cache_tag_store.sv
source/cache_data_store.sv
source/backing_mem.sv
source/cache_apb_top.sv
verification/cache_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module cache_tb -f files.f

output=$(./obj_dir/Vcache_tb 2>&1) || true
echo "$output"

if echo "$output" | grep -q "ALL TESTS PASSED"; then
    exit 0
else
    exit 1
fi
